/* build.f */
+incdir+src
src/if_pkg.sv
src/icache_line.sv
src/icache_lookup.sv
src/fetch_stage.sv
src/if_top.sv
testbench/if_top_checker.sv
testbench/if_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the fetch testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module if_top_tb -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vif_top_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

/* src/fetch_stage.sv */
`default_nettype none
`include "if_config.svh"

module fetch_stage (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              stall_i,

    input  logic              cache_hit_i,
    input  if_pkg::word_t     cache_word_i,
    output if_pkg::tag_t      lookup_tag_o,
    output if_pkg::word_sel_t word_sel_o,

    input  logic              fill_valid_i,
    input  if_pkg::line_idx_t fill_index_i,
    input  if_pkg::lane_t     fill_lane_i,
    output if_pkg::line_vec_t fill_en_o,
    output if_pkg::tag_t      fill_tag_o,
    output if_pkg::lane_t     fill_lane_o,

    output logic              miss_o,
    output logic              stall_o,
    output if_pkg::addr_t     miss_addr_o,

    input  logic              branch_done_i,
    input  logic              branch_taken_i,
    input  if_pkg::addr_t     branch_target_i,

    output if_pkg::word_t     instr_o,
    output if_pkg::addr_t     pc_o
);

    if_pkg::fetch_state_e state_q;
    if_pkg::fetch_state_e state_d;
    if_pkg::addr_t        pc_q;
    if_pkg::addr_t        pc_d;
    if_pkg::word_t        instr_d;
    if_pkg::addr_t        pc_out_d;
    logic [6:0]           opcode;
    logic                 is_branch;
    logic                 fill_take;

    assign opcode    = cache_word_i[6:0];
    assign is_branch = (opcode == `IF_OPCODE_BRANCH) ||
                       (opcode == `IF_OPCODE_JAL)    ||
                       (opcode == `IF_OPCODE_JALR);

    assign lookup_tag_o = pc_q[`IF_WORD_WIDTH-1:`IF_OFFSET_BITS];
    assign word_sel_o   = pc_q[`IF_OFFSET_BITS-1:2];

    // a fill always lands under the tag of the pc that missed.
    assign fill_take   = (state_q == if_pkg::FETCH_MISS) && fill_valid_i;
    assign fill_tag_o  = pc_q[`IF_WORD_WIDTH-1:`IF_OFFSET_BITS];
    assign fill_lane_o = fill_lane_i;

    always_comb begin
        fill_en_o = '0;
        if (fill_take) begin
            fill_en_o[fill_index_i] = 1'b1;  // one-hot slot.
        end
    end

    assign miss_o = (state_q == if_pkg::FETCH_MISS) ||
                    ((state_q == if_pkg::FETCH_RUN) && !cache_hit_i);
    assign stall_o     = miss_o;
    assign miss_addr_o = {pc_q[`IF_WORD_WIDTH-1:`IF_OFFSET_BITS], {`IF_OFFSET_BITS{1'b0}}};

    always_comb begin
        state_d  = state_q;
        pc_d     = pc_q;
        instr_d  = instr_o;
        pc_out_d = pc_o;
        unique case (state_q)
            if_pkg::FETCH_RUN: begin
                if (!stall_i && cache_hit_i) begin
                    instr_d  = cache_word_i;
                    pc_out_d = pc_q;
                    pc_d     = pc_q + 32'd4;
                    if (is_branch) begin
                        state_d = if_pkg::FETCH_BRANCH;
                    end
                end else if (!stall_i) begin
                    instr_d = `IF_NOP;  // bubble while the line loads.
                    state_d = if_pkg::FETCH_MISS;
                end
            end
            if_pkg::FETCH_MISS: begin
                // fill is taken even under stall.
                if (fill_take) begin
                    state_d = if_pkg::FETCH_RUN;
                end
            end
            if_pkg::FETCH_BRANCH: begin
                if (!stall_i) begin
                    instr_d = `IF_NOP;
                    if (branch_done_i) begin
                        state_d = if_pkg::FETCH_RUN;
                        if (branch_taken_i) begin
                            pc_d = branch_target_i;
                        end
                    end
                end
            end
            default: state_d = if_pkg::FETCH_RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= if_pkg::FETCH_RUN;
            pc_q    <= '0;
            instr_o <= `IF_NOP;
            pc_o    <= '0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            instr_o <= instr_d;
            pc_o    <= pc_out_d;
        end
    end

endmodule : fetch_stage

`default_nettype wire

/* src/icache_line.sv */
`default_nettype none
`include "if_config.svh"

module icache_line (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              fill_i,
    input  if_pkg::tag_t      fill_tag_i,
    input  if_pkg::lane_t     fill_lane_i,
    input  if_pkg::tag_t      lookup_tag_i,
    input  if_pkg::word_sel_t word_sel_i,
    output logic              hit_o,
    output if_pkg::word_t     word_o
);

    logic          valid_q;
    if_pkg::tag_t  tag_q;
    if_pkg::lane_t lane_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (fill_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q  <= fill_tag_i;
            lane_q <= fill_lane_i;
        end
    end

    assign hit_o = valid_q && (tag_q == lookup_tag_i);

    // zero on a miss so the lookup can OR the lines together.
    always_comb begin
        word_o = '0;
        if (hit_o) begin
            word_o = lane_q[word_sel_i*`IF_WORD_WIDTH +: `IF_WORD_WIDTH];
        end
    end

endmodule : icache_line

`default_nettype wire

/* src/icache_lookup.sv */
`default_nettype none
`include "if_config.svh"

module icache_lookup (
    input  if_pkg::line_vec_t hits_i,
    input  if_pkg::word_t     words_i [`IF_NUM_LINES],
    output logic              hit_o,
    output if_pkg::word_t     word_o
);

    assign hit_o = |hits_i;

    // fully associative, so at most one line hits.
    always_comb begin
        word_o = '0;
        for (int i = 0; i < `IF_NUM_LINES; i++) begin
            if (hits_i[i]) begin
                word_o = word_o | words_i[i];
            end
        end
    end

endmodule : icache_lookup

`default_nettype wire

/* src/if_config.svh */
`ifndef IF_CONFIG_SVH
`define IF_CONFIG_SVH

// instruction and address width.
`define IF_WORD_WIDTH 32

// cache geometry.
`define IF_NUM_LINES  4
`define IF_LINE_WORDS 4

// byte offset inside one line.
`define IF_OFFSET_BITS ($clog2(`IF_LINE_WORDS) + 2)

// opcodes that hold fetch until the branch resolves.
`define IF_OPCODE_BRANCH 7'b1100011
`define IF_OPCODE_JAL    7'b1101111
`define IF_OPCODE_JALR   7'b1100111

// addi x0, x0, 0.
`define IF_NOP 32'h00000013

`endif

/* src/if_pkg.sv */
`default_nettype none
`include "if_config.svh"

package if_pkg;

    typedef logic [`IF_WORD_WIDTH-1:0] word_t;
    typedef logic [`IF_WORD_WIDTH-1:0] addr_t;

    // address bits above the line offset.
    typedef logic [`IF_WORD_WIDTH-`IF_OFFSET_BITS-1:0] tag_t;

    // word 0 in the low bits.
    typedef logic [`IF_WORD_WIDTH*`IF_LINE_WORDS-1:0] lane_t;

    typedef logic [$clog2(`IF_LINE_WORDS)-1:0] word_sel_t;
    typedef logic [$clog2(`IF_NUM_LINES)-1:0]  line_idx_t;
    typedef logic [`IF_NUM_LINES-1:0]          line_vec_t;

    typedef enum logic [1:0] {
        FETCH_RUN,
        FETCH_MISS,
        FETCH_BRANCH
    } fetch_state_e;

endpackage : if_pkg

`default_nettype wire

/* src/if_top.sv */
`default_nettype none
`include "if_config.svh"

module if_top (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              stall_i,
    input  logic              fill_valid_i,
    input  if_pkg::line_idx_t fill_index_i,
    input  if_pkg::lane_t     fill_lane_i,
    input  logic              branch_done_i,
    input  logic              branch_taken_i,
    input  if_pkg::addr_t     branch_target_i,
    output if_pkg::word_t     instr_o,
    output if_pkg::addr_t     pc_o,
    output logic              miss_o,
    output if_pkg::addr_t     miss_addr_o,
    output logic              stall_o
);

    if_pkg::tag_t      lookup_tag;
    if_pkg::word_sel_t word_sel;
    if_pkg::line_vec_t fill_en;
    if_pkg::tag_t      fill_tag;
    if_pkg::lane_t     fill_lane;
    if_pkg::line_vec_t line_hits;
    if_pkg::word_t     line_words [`IF_NUM_LINES];
    logic              cache_hit;
    if_pkg::word_t     cache_word;

    fetch_stage u_fetch_stage (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .stall_i         (stall_i),
        .cache_hit_i     (cache_hit),
        .cache_word_i    (cache_word),
        .lookup_tag_o    (lookup_tag),
        .word_sel_o      (word_sel),
        .fill_valid_i    (fill_valid_i),
        .fill_index_i    (fill_index_i),
        .fill_lane_i     (fill_lane_i),
        .fill_en_o       (fill_en),
        .fill_tag_o      (fill_tag),
        .fill_lane_o     (fill_lane),
        .miss_o          (miss_o),
        .stall_o         (stall_o),
        .miss_addr_o     (miss_addr_o),
        .branch_done_i   (branch_done_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .instr_o         (instr_o),
        .pc_o            (pc_o)
    );

    for (genvar i = 0; i < `IF_NUM_LINES; i++) begin : g_line
        icache_line u_icache_line (
            .clk_i        (clk_i),
            .reset_i      (reset_i),
            .fill_i       (fill_en[i]),
            .fill_tag_i   (fill_tag),
            .fill_lane_i  (fill_lane),
            .lookup_tag_i (lookup_tag),
            .word_sel_i   (word_sel),
            .hit_o        (line_hits[i]),
            .word_o       (line_words[i])
        );
    end

    icache_lookup u_icache_lookup (
        .hits_i  (line_hits),
        .words_i (line_words),
        .hit_o   (cache_hit),
        .word_o  (cache_word)
    );

endmodule : if_top

`default_nettype wire

/* testbench/if_top_checker.sv */
`default_nettype none
`include "if_config.svh"

module if_top_checker (
    input logic          clk_i,
    input logic          reset_i,
    input logic          stall_i,
    input logic          fill_valid_i,
    input logic          miss_o,
    input logic          stall_o,
    input if_pkg::word_t instr_o,
    input if_pkg::addr_t pc_o
);
    timeunit 1ns;
    timeprecision 1ps;

    assert property (@(posedge clk_i) disable iff (reset_i) stall_o == miss_o)
        else $error("stall_o differs from miss_o");

    assert property (@(posedge clk_i) reset_i |=> instr_o == `IF_NOP)
        else $error("instr_o is not the NOP after a reset cycle");

    // downstream stall freezes the output pc.
    assert property (@(posedge clk_i) disable iff (reset_i) stall_i |=> $stable(pc_o))
        else $error("pc_o moved while stall_i was high");

    assert property (@(posedge clk_i) disable iff (reset_i) fill_valid_i |-> miss_o)
        else $error("fill_valid_i arrived with no miss pending");

endmodule : if_top_checker

bind if_top if_top_checker u_if_top_checker (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .stall_i      (stall_i),
    .fill_valid_i (fill_valid_i),
    .miss_o       (miss_o),
    .stall_o      (stall_o),
    .instr_o      (instr_o),
    .pc_o         (pc_o)
);

`default_nettype wire

/* testbench/if_top_tb.sv */
`default_nettype none
`include "if_config.svh"

module if_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 400;  // the tests need under 200.

    logic              clk_i;
    logic              reset_i;
    logic              stall_i;
    logic              fill_valid_i;
    if_pkg::line_idx_t fill_index_i;
    if_pkg::lane_t     fill_lane_i;
    logic              branch_done_i;
    logic              branch_taken_i;
    if_pkg::addr_t     branch_target_i;
    if_pkg::word_t     instr_o;
    if_pkg::addr_t     pc_o;
    logic              miss_o;
    if_pkg::addr_t     miss_addr_o;
    logic              stall_o;

    if_pkg::word_t     prog [64];  // backing memory, 256 bytes.
    logic [31:0]       lcg_state = 32'hd0d93022;
    int                cycle_count = 0;

    if_top u_if_top (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .stall_i         (stall_i),
        .fill_valid_i    (fill_valid_i),
        .fill_index_i    (fill_index_i),
        .fill_lane_i     (fill_lane_i),
        .branch_done_i   (branch_done_i),
        .branch_taken_i  (branch_taken_i),
        .branch_target_i (branch_target_i),
        .instr_o         (instr_o),
        .pc_o            (pc_o),
        .miss_o          (miss_o),
        .miss_addr_o     (miss_addr_o),
        .stall_o         (stall_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input if_pkg::word_t act,
                              input if_pkg::word_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input if_pkg::addr_t act,
                              input if_pkg::addr_t exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, act, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, act, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic if_pkg::word_t prog_at(input if_pkg::addr_t a);
        return prog[a[7:2]];
    endfunction

    function automatic if_pkg::lane_t lane_of(input if_pkg::addr_t base);
        if_pkg::lane_t lane;
        for (int w = 0; w < `IF_LINE_WORDS; w++) begin
            lane[w*`IF_WORD_WIDTH +: `IF_WORD_WIDTH] = prog[{base[7:4], w[1:0]}];
        end
        return lane;
    endfunction

    task automatic load_program();
        if_pkg::addr_t a;
        for (int i = 0; i < 64; i++) begin
            a = if_pkg::addr_t'(i) << 2;
            prog[i[5:0]] = {~a[24:0], 7'b0010011};  // op-imm, marked by address.
        end
        prog[6'd5][6:0]  = `IF_OPCODE_BRANCH;  // at 0x14.
        prog[6'd19][6:0] = `IF_OPCODE_JAL;     // at 0x4c.
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // memory side: answer the pending miss after 1 to 4 cycles.
    task automatic serve_miss(input if_pkg::line_idx_t slot, input if_pkg::addr_t exp_addr);
        int delay;
        while (miss_o !== 1'b1) begin
            next_cycle();
        end
        check_addr("miss_addr_o", miss_addr_o, exp_addr);
        lcg_state = lcg_next(lcg_state);
        delay = 1 + int'(lcg_state[17:16]);
        repeat (delay) next_cycle();
        fill_valid_i = 1'b1;
        fill_index_i = slot;
        fill_lane_i  = lane_of(exp_addr);
        next_cycle();
        fill_valid_i = 1'b0;
    endtask

    task automatic expect_stream(input if_pkg::addr_t start, input int count);
        if_pkg::addr_t a;
        for (int i = 0; i < count; i++) begin
            a = start + if_pkg::addr_t'(4 * i);
            next_cycle();
            check_word("instr_o", instr_o, prog_at(a));
            check_addr("pc_o", pc_o, a);
        end
    endtask

    // branch unit: bubbles while unresolved, then a one-cycle done strobe.
    task automatic resolve_branch(input logic taken, input if_pkg::addr_t target,
                                  input if_pkg::addr_t branch_pc);
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            check_word("instr_o", instr_o, `IF_NOP);
            check_addr("pc_o", pc_o, branch_pc);
        end
        branch_done_i   = 1'b1;
        branch_taken_i  = taken;
        branch_target_i = target;
        next_cycle();
        branch_done_i  = 1'b0;
        branch_taken_i = 1'b0;
        check_word("instr_o", instr_o, `IF_NOP);
    endtask

    task automatic reset_state();
        reset_i = 1'b1;
        repeat (2) next_cycle();
        reset_i = 1'b0;
        check_word("instr_o", instr_o, `IF_NOP);
        check_addr("pc_o", pc_o, 32'h0);
        check_bit("miss_o", miss_o, 1'b1);  // no valid lines yet.
        check_bit("stall_o", stall_o, 1'b1);
        check_addr("miss_addr_o", miss_addr_o, 32'h0);
    endtask

    task automatic cold_miss_stream();
        serve_miss(2'd0, 32'h0);
        expect_stream(32'h0, 4);
        check_bit("miss_o", miss_o, 1'b1);
        check_bit("stall_o", stall_o, 1'b1);
        check_addr("miss_addr_o", miss_addr_o, 32'h10);
    endtask

    task automatic branch_not_taken();
        serve_miss(2'd1, 32'h10);
        expect_stream(32'h10, 2);
        resolve_branch(1'b0, 32'h40, 32'h14);
        check_bit("miss_o", miss_o, 1'b0);
        check_bit("stall_o", stall_o, 1'b0);
        expect_stream(32'h18, 2);
    endtask

    task automatic line_replacement();
        serve_miss(2'd2, 32'h20);
        expect_stream(32'h20, 4);
        serve_miss(2'd3, 32'h30);
        expect_stream(32'h30, 4);
        serve_miss(2'd0, 32'h40);  // evicts line 0.
        expect_stream(32'h40, 4);
        resolve_branch(1'b1, 32'h10, 32'h4c);
        check_bit("miss_o", miss_o, 1'b0);
        expect_stream(32'h10, 2);
        resolve_branch(1'b1, 32'h0, 32'h14);
        check_bit("miss_o", miss_o, 1'b1);
        check_bit("stall_o", stall_o, 1'b1);
        check_addr("miss_addr_o", miss_addr_o, 32'h0);
    endtask

    task automatic stall_hold();
        serve_miss(2'd2, 32'h0);
        expect_stream(32'h0, 2);
        stall_i = 1'b1;
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            check_word("instr_o", instr_o, prog_at(32'h4));
            check_addr("pc_o", pc_o, 32'h4);
        end
        stall_i = 1'b0;
        expect_stream(32'h8, 3);
    endtask

    initial begin
        clk_i           = 1'b0;
        reset_i         = 1'b1;
        stall_i         = 1'b0;
        fill_valid_i    = 1'b0;
        fill_index_i    = '0;
        fill_lane_i     = '0;
        branch_done_i   = 1'b0;
        branch_taken_i  = 1'b0;
        branch_target_i = '0;
        load_program();
        reset_state();
        cold_miss_stream();
        branch_not_taken();
        line_replacement();
        stall_hold();
        $display("=== PASS ===");
        $finish;
    end

endmodule : if_top_tb

`default_nettype wire
